// File: hdl/hdmi_cfg_pkg.sv
/*
 * Shared types and constants for the HDMI bridge start-up configuration.
 * CFG_TABLE entries are {register, data}; the table is sent in index order.
 */
`default_nettype none

package hdmi_cfg_pkg;

	// Command opcode, top bit of a command word
	typedef enum logic {
		OP_REG_WRITE = 1'b0,
		OP_END       = 1'b1
	} cmd_op_e;

	// I2C write master states
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_START,
		ST_BIT,
		ST_ACK,
		ST_STOP
	} i2c_state_e;

	// Command word fields: {op, register, data}
	localparam int REG_W  = 8;
	localparam int DATA_W = 8;
	localparam int CMD_W  = 1 + REG_W + DATA_W;

	// 7-bit address of the bridge chip
	localparam logic [6:0] DEV_ADDR = 7'h4C;

	//////////////////////////////////////////////////
	// Register write table
	//////////////////////////////////////////////////
	localparam int CFG_LEN = 8;

	localparam logic [REG_W+DATA_W-1:0] CFG_TABLE [CFG_LEN] = '{
		16'h04_3D,	// Hold all cores in reset
		16'h04_1D,	// Release the register core
		16'h61_30,	// Power down analog front end
		16'h0F_00,	// Select register bank 0
		16'h62_18,	// PLL charge pump and filter
		16'h64_1D,	// Output driver level
		16'h6A_00,	// Clear the AFE test mode
		16'h04_15	// Release the video path reset
	};

endpackage

`default_nettype wire

// File: hdl/cfg_rom_sequencer.sv
/*
 * Pushes CFG_TABLE as write commands, then one OP_END, while i_run is high.
 * Stops after OP_END; a fall of i_run rewinds to entry 0.
 */
`default_nettype none

module cfg_rom_sequencer (
	input  logic                           i_sysclk,
	input  logic                           i_arstn,
	input  logic                           i_run,
	input  logic                           i_full,
	output logic                           o_wr,
	output logic [hdmi_cfg_pkg::CMD_W-1:0] o_cmd
);

	// Index runs 0..CFG_LEN, the last value selecting OP_END
	localparam int IW = $clog2(hdmi_cfg_pkg::CFG_LEN + 1);
	localparam int AW = $clog2(hdmi_cfg_pkg::CFG_LEN);

	logic [IW-1:0] idx;
	logic          fin;
	logic          at_end;

	assign at_end = (idx == IW'(hdmi_cfg_pkg::CFG_LEN));

	// Push every cycle the FIFO has room
	assign o_wr = i_run && !fin && !i_full;

	//////////////////////////////////////////////////
	// Command word from the table
	//////////////////////////////////////////////////
	always_comb
	begin
		if (at_end)
		begin
			// End marker carries no bus transfer
			o_cmd = {hdmi_cfg_pkg::OP_END, {(hdmi_cfg_pkg::CMD_W-1){1'b0}}};
		end
		else
		begin
			o_cmd = {hdmi_cfg_pkg::OP_REG_WRITE, hdmi_cfg_pkg::CFG_TABLE[idx[AW-1:0]]};
		end
	end

	//////////////////////////////////////////////////
	// Entry index
	//////////////////////////////////////////////////
	always_ff @(posedge i_sysclk)
	begin
		if (!i_arstn)
		begin
			idx <= '0;
			fin <= 1'b0;
		end
		else if (!i_run)
		begin
			// Loss of run restarts the table
			idx <= '0;
			fin <= 1'b0;
		end
		else if (o_wr)
		begin
			if (at_end)
			begin
				fin <= 1'b1;
			end
			else
			begin
				idx <= idx + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/i2c_cmd_fifo.sv
/*
 * First-word fall-through command buffer, FIFO_DEPTH a power of two >= 2.
 * No overflow or underflow protection; the writer and reader obey the flags.
 */
`default_nettype none

module i2c_cmd_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                           i_sysclk,
	input  logic                           i_arstn,
	input  logic                           i_clr,
	input  logic                           i_wr,
	input  logic [hdmi_cfg_pkg::CMD_W-1:0] i_wdata,
	input  logic                           i_rd,
	output logic [hdmi_cfg_pkg::CMD_W-1:0] o_rdata,
	output logic                           o_full,
	output logic                           o_empty
);

	localparam int AW = $clog2(FIFO_DEPTH);

	logic [hdmi_cfg_pkg::CMD_W-1:0] mem [FIFO_DEPTH];
	logic [AW:0]                    wr_ptr;
	logic [AW:0]                    rd_ptr;

	// Extra top bit tells full from empty
	assign o_empty = (wr_ptr == rd_ptr);
	assign o_full  = (wr_ptr == {~rd_ptr[AW], rd_ptr[AW-1:0]});

	// Head word, valid while not empty
	assign o_rdata = mem[rd_ptr[AW-1:0]];

	always_ff @(posedge i_sysclk)
	begin
		if (!i_arstn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else if (i_clr)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (i_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (i_rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// Storage
	always_ff @(posedge i_sysclk)
	begin
		if (i_wr)
			mem[wr_ptr[AW-1:0]] <= i_wdata;
	end

	a_no_overflow: assert property (
		@(posedge i_sysclk) disable iff (!i_arstn)
		i_wr |-> !o_full
	);

	a_no_underflow: assert property (
		@(posedge i_sysclk) disable iff (!i_arstn)
		i_rd |-> !o_empty
	);

endmodule

`default_nettype wire

// File: hdl/i2c_write_master.sv
/*
 * Open-drain I2C write master: start, device address, register, data, stop.
 * i_scl and i_sda are taken as synchronous to i_sysclk; CLK_DIV must be >= 2.
 * i_hold aborts any transfer and keeps the master idle.
 */
`default_nettype none

module i2c_write_master #(
	parameter int CLK_DIV = 4
) (
	input  logic                           i_sysclk,
	input  logic                           i_arstn,
	input  logic                           i_hold,
	input  logic                           i_empty,
	input  logic [hdmi_cfg_pkg::CMD_W-1:0] i_cmd,
	input  logic                           i_scl,
	input  logic                           i_sda,
	output logic                           o_rd,
	output logic                           o_scl_oe,
	output logic                           o_sda_oe,
	output logic                           o_xfer_done,
	output logic                           o_nack,
	output logic                           o_end,
	output hdmi_cfg_pkg::i2c_state_e       o_state
);

	localparam int DW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
	localparam int RW = hdmi_cfg_pkg::REG_W;
	localparam int BW = hdmi_cfg_pkg::DATA_W;

	hdmi_cfg_pkg::i2c_state_e state;

	logic [DW-1:0] div_cnt;
	logic [1:0]    phase;
	logic [2:0]    bit_cnt;
	logic [1:0]    byte_cnt;
	logic [7:0]    shift;
	logic [RW-1:0] reg_q;
	logic [BW-1:0] data_q;
	logic          ack_bad;
	logic          stretch;
	logic          qtick;
	logic          bit_end;
	logic          pop;
	logic          is_end;
	logic          scl_drv;
	logic          sda_upd;
	logic          sda_val;

	// Take the head word when idle
	assign pop    = (state == hdmi_cfg_pkg::ST_IDLE) && !i_hold && !i_empty;
	assign is_end = (hdmi_cfg_pkg::cmd_op_e'(i_cmd[hdmi_cfg_pkg::CMD_W-1]) == hdmi_cfg_pkg::OP_END);
	assign o_rd   = pop;

	// SCL released but held low by the slave
	assign stretch = !o_scl_oe && !i_scl;
	assign qtick   = (state != hdmi_cfg_pkg::ST_IDLE) && !stretch
		&& (div_cnt == DW'(CLK_DIV - 1));
	assign bit_end = qtick && (phase == 2'd3);

	//////////////////////////////////////////////////
	// Line decode per quarter
	//////////////////////////////////////////////////
	// Quarters 0,1 SCL low, 2,3 released; SDA moves in quarter 1
	assign scl_drv = (state inside {hdmi_cfg_pkg::ST_BIT, hdmi_cfg_pkg::ST_ACK,
		hdmi_cfg_pkg::ST_STOP}) && !phase[1];

	always_comb
	begin
		sda_upd = (phase != 2'd0);
		sda_val = 1'b0;
		case (state)
			hdmi_cfg_pkg::ST_IDLE:  sda_upd = 1'b1;
			// SDA falls in the second half with SCL high
			hdmi_cfg_pkg::ST_START:
			begin
				sda_upd = 1'b1;
				sda_val = phase[1];
			end
			hdmi_cfg_pkg::ST_BIT:   sda_val = !shift[7];
			hdmi_cfg_pkg::ST_ACK:   sda_val = 1'b0;
			// Low under SCL, released last for the stop
			hdmi_cfg_pkg::ST_STOP:  sda_val = (phase != 2'd3);
			default:                sda_upd = 1'b1;
		endcase
	end

	//////////////////////////////////////////////////
	// Control FSM
	//////////////////////////////////////////////////
	always_ff @(posedge i_sysclk)
	begin
		if (!i_arstn || i_hold)
		begin
			// Abort releases both lines at once
			state       <= hdmi_cfg_pkg::ST_IDLE;
			div_cnt     <= '0;
			phase       <= 2'd0;
			bit_cnt     <= 3'd0;
			byte_cnt    <= 2'd0;
			ack_bad     <= 1'b0;
			o_scl_oe    <= 1'b0;
			o_sda_oe    <= 1'b0;
			o_xfer_done <= 1'b0;
			o_nack      <= 1'b0;
			o_end       <= 1'b0;
		end
		else
		begin
			o_xfer_done <= 1'b0;
			o_nack      <= 1'b0;
			o_end       <= 1'b0;
			o_scl_oe    <= scl_drv;
			if (sda_upd)
				o_sda_oe <= sda_val;

			// Quarter divider, frozen while stretched
			if (state == hdmi_cfg_pkg::ST_IDLE || qtick)
				div_cnt <= '0;
			else if (!stretch)
				div_cnt <= div_cnt + 1'b1;
			if (qtick)
				phase <= phase + 1'b1;

			case (state)
				hdmi_cfg_pkg::ST_IDLE:
				begin
					if (pop)
					begin
						phase    <= 2'd0;
						bit_cnt  <= 3'd7;
						byte_cnt <= 2'd0;
						ack_bad  <= 1'b0;
						if (is_end)
							o_end <= 1'b1;
						else
							state <= hdmi_cfg_pkg::ST_START;
					end
				end
				hdmi_cfg_pkg::ST_START:
				begin
					if (bit_end)
						state <= hdmi_cfg_pkg::ST_BIT;
				end
				hdmi_cfg_pkg::ST_BIT:
				begin
					if (bit_end)
					begin
						if (bit_cnt == 3'd0)
							state <= hdmi_cfg_pkg::ST_ACK;
						else
							bit_cnt <= bit_cnt - 1'b1;
					end
				end
				hdmi_cfg_pkg::ST_ACK:
				begin
					// Sample in the middle of SCL high, high line is a NACK
					if (qtick && phase == 2'd2)
						ack_bad <= i_sda;
					if (bit_end)
					begin
						if (ack_bad || byte_cnt == 2'd2)
						begin
							state <= hdmi_cfg_pkg::ST_STOP;
						end
						else
						begin
							state    <= hdmi_cfg_pkg::ST_BIT;
							bit_cnt  <= 3'd7;
							byte_cnt <= byte_cnt + 1'b1;
						end
					end
				end
				hdmi_cfg_pkg::ST_STOP:
				begin
					if (bit_end)
					begin
						state       <= hdmi_cfg_pkg::ST_IDLE;
						o_xfer_done <= 1'b1;
						o_nack      <= ack_bad;
					end
				end
				default: state <= hdmi_cfg_pkg::ST_IDLE;
			endcase
		end
	end

	// Byte shifter and latched command payload
	always_ff @(posedge i_sysclk)
	begin
		if (pop)
		begin
			shift  <= {hdmi_cfg_pkg::DEV_ADDR, 1'b0};
			reg_q  <= i_cmd[BW +: RW];
			data_q <= i_cmd[BW-1:0];
		end
		else if (bit_end && state == hdmi_cfg_pkg::ST_BIT)
		begin
			shift <= {shift[6:0], 1'b0};
		end
		else if (bit_end && state == hdmi_cfg_pkg::ST_ACK)
		begin
			shift <= (byte_cnt == 2'd0) ? reg_q : data_q;
		end
	end

	assign o_state = state;

	// Lines lag state by a cycle; SDA may move under high SCL only at start/stop
	a_sda_stable: assert property (
		@(posedge i_sysclk) disable iff (!i_arstn)
		($changed(o_sda_oe) && !o_scl_oe) |->
			($past(state) inside {hdmi_cfg_pkg::ST_START, hdmi_cfg_pkg::ST_STOP}
			|| $past(i_hold))
	);

endmodule

`default_nettype wire

// File: hdl/hdmi_bridge_config.sv
/*
 * Bridge start-up: sequencer, command FIFO and I2C write master.
 * Done and error are sticky until reset or loss of PLL lock.
 */
`default_nettype none

module hdmi_bridge_config #(
	parameter int CLK_DIV    = 4,
	parameter int FIFO_DEPTH = 4
) (
	input  logic                     i_sysclk,
	input  logic                     i_arstn,
	input  logic                     i_pll_locked,
	input  logic                     i_scl,
	input  logic                     i_sda,
	output logic                     o_scl_oe,
	output logic                     o_sda_oe,
	output logic                     o_rstn,
	output logic                     o_confdone,
	output logic                     o_error,
	output hdmi_cfg_pkg::i2c_state_e o_state
);

	localparam int CW = $clog2(hdmi_cfg_pkg::CFG_LEN + 1);

	logic                           run;
	logic                           hold;
	logic                           wr;
	logic [hdmi_cfg_pkg::CMD_W-1:0] wcmd;
	logic                           full;
	logic                           empty;
	logic                           rd;
	logic [hdmi_cfg_pkg::CMD_W-1:0] head;
	logic                           xfer_done;
	logic                           nack;
	logic                           end_pulse;
	logic [CW-1:0]                  wr_cnt;

	// Run only with lock and no error
	assign run  = i_pll_locked && !o_error;
	assign hold = o_error || !i_pll_locked;

	// Chip comes out of reset with the PLL
	assign o_rstn = i_pll_locked;

	cfg_rom_sequencer u_seq (
		.i_sysclk (i_sysclk),
		.i_arstn  (i_arstn),
		.i_run    (run),
		.i_full   (full),
		.o_wr     (wr),
		.o_cmd    (wcmd)
	);

	i2c_cmd_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.i_sysclk (i_sysclk),
		.i_arstn  (i_arstn),
		.i_clr    (!i_pll_locked),
		.i_wr     (wr),
		.i_wdata  (wcmd),
		.i_rd     (rd),
		.o_rdata  (head),
		.o_full   (full),
		.o_empty  (empty)
	);

	i2c_write_master #(
		.CLK_DIV (CLK_DIV)
	) u_master (
		.i_sysclk    (i_sysclk),
		.i_arstn     (i_arstn),
		.i_hold      (hold),
		.i_empty     (empty),
		.i_cmd       (head),
		.i_scl       (i_scl),
		.i_sda       (i_sda),
		.o_rd        (rd),
		.o_scl_oe    (o_scl_oe),
		.o_sda_oe    (o_sda_oe),
		.o_xfer_done (xfer_done),
		.o_nack      (nack),
		.o_end       (end_pulse),
		.o_state     (o_state)
	);

	//////////////////////////////////////////////////
	// Status flags
	//////////////////////////////////////////////////
	always_ff @(posedge i_sysclk)
	begin
		if (!i_arstn || !i_pll_locked)
		begin
			o_confdone <= 1'b0;
			o_error    <= 1'b0;
			wr_cnt     <= '0;
		end
		else
		begin
			// Count acknowledged writes
			if (xfer_done && !nack)
				wr_cnt <= wr_cnt + 1'b1;
			if (nack)
				o_error <= 1'b1;
			// Done only when every table entry went out
			if (end_pulse && wr_cnt == CW'(hdmi_cfg_pkg::CFG_LEN))
				o_confdone <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: hdl/hdmi_cam_ctrl_top.sv
/*
 * Image-path control and HDMI bridge I2C pins.
 * The image selector is fixed by CBSEL_IMAGE; the enable is always high.
 */
`default_nettype none

module hdmi_cam_ctrl_top #(
	parameter int         CLK_DIV     = 4,
	parameter int         FIFO_DEPTH  = 4,
	parameter logic [1:0] CBSEL_IMAGE = 2'b01
) (
	input  logic                     i_sysclk,
	input  logic                     i_arstn,
	input  logic                     i_pll_locked,
	// Bridge chip I2C, open drain
	input  logic                     i_hdmi_scl,
	input  logic                     i_hdmi_sda,
	output logic                     o_hdmi_scl_oe,
	output logic                     o_hdmi_sda_oe,
	output logic                     o_hdmi_xclr,
	output logic                     o_hdmi_rstn,
	// Image-path control
	output logic                     o_cfg_config,
	output logic                     o_cfg_error,
	output logic                     o_cfg_ena,
	output logic [1:0]               o_cfg_cbsel,
	output hdmi_cfg_pkg::i2c_state_e o_i2c_state
);

	logic chip_rstn;

	hdmi_bridge_config #(
		.CLK_DIV    (CLK_DIV),
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_bridge_cfg (
		.i_sysclk     (i_sysclk),
		.i_arstn      (i_arstn),
		.i_pll_locked (i_pll_locked),
		.i_scl        (i_hdmi_scl),
		.i_sda        (i_hdmi_sda),
		.o_scl_oe     (o_hdmi_scl_oe),
		.o_sda_oe     (o_hdmi_sda_oe),
		.o_rstn       (chip_rstn),
		.o_confdone   (o_cfg_config),
		.o_error      (o_cfg_error),
		.o_state      (o_i2c_state)
	);

	// Both chip reset pins follow the PLL
	assign o_hdmi_rstn = chip_rstn;
	assign o_hdmi_xclr = chip_rstn;

	// Fixed image selection
	assign o_cfg_ena   = 1'b1;
	assign o_cfg_cbsel = CBSEL_IMAGE;

endmodule

`default_nettype wire

// File: dv/i2c_slave_model.sv
/*
 * Bus-level model of the HDMI bridge chip: I2C writes only, 7-bit address.
 * Samples the lines and drives its pull-downs 2 time units after each clock edge.
 * A frame numbered i_nack_idx is NACKed on its register byte.
 */
`default_nettype none

module i2c_slave_model (
	input  logic        i_sysclk,
	input  logic        i_restart,
	input  logic        i_scl,
	input  logic        i_sda,
	input  int          i_nack_idx,
	input  int          i_stretch_len,
	output logic        o_scl_low,
	output logic        o_sda_low,
	output logic        o_pair_valid,
	output logic [6:0]  o_addr,
	output logic [15:0] o_pair
);

	logic       scl_q;
	logic       sda_q;
	logic       in_frame;
	logic       nacked;
	logic       ack;
	int         bit_cnt;
	int         byte_cnt;
	int         frame_cnt;
	int         hold_cnt;
	logic [7:0] shreg;
	logic [7:0] bytes [3];

	initial
	begin
		scl_q        = 1'b1;
		sda_q        = 1'b1;
		in_frame     = 1'b0;
		nacked       = 1'b0;
		ack          = 1'b0;
		bit_cnt      = 0;
		byte_cnt     = 0;
		frame_cnt    = 0;
		hold_cnt     = 0;
		shreg        = '0;
		o_scl_low    = 1'b0;
		o_sda_low    = 1'b0;
		o_pair_valid = 1'b0;
		o_addr       = '0;
		o_pair       = '0;
	end

	always @(posedge i_sysclk)
	begin
		#2;
		o_pair_valid = 1'b0;
		if (i_restart)
		begin
			// Back to an idle bus, frame numbering from 0
			in_frame  = 1'b0;
			nacked    = 1'b0;
			bit_cnt   = 0;
			byte_cnt  = 0;
			frame_cnt = 0;
			hold_cnt  = 0;
			o_scl_low = 1'b0;
			o_sda_low = 1'b0;
		end
		else
		begin
			// Clock stretch countdown
			if (hold_cnt > 0)
				hold_cnt--;
			o_scl_low = (hold_cnt > 0);

			if (i_scl && scl_q && sda_q && !i_sda)
			begin
				// Start: SDA falls under high SCL
				in_frame = 1'b1;
				nacked   = 1'b0;
				bit_cnt  = 0;
				byte_cnt = 0;
			end
			else if (i_scl && scl_q && !sda_q && i_sda)
			begin
				// Stop: report a complete, fully acknowledged write
				if (in_frame && byte_cnt == 3 && !nacked)
				begin
					o_addr       = bytes[0][7:1];
					o_pair       = {bytes[1], bytes[2]};
					o_pair_valid = 1'b1;
				end
				if (in_frame)
					frame_cnt++;
				in_frame = 1'b0;
			end
			else if (in_frame && i_scl && !scl_q)
			begin
				// Data bits MSB first, ninth clock is the ACK slot
				if (bit_cnt < 8)
					shreg = {shreg[6:0], i_sda};
				bit_cnt++;
			end
			else if (in_frame && !i_scl && scl_q)
			begin
				hold_cnt  = i_stretch_len;
				o_scl_low = (hold_cnt > 0);
				if (bit_cnt == 8)
				begin
					bytes[byte_cnt] = shreg;
					if (byte_cnt == 0)
						ack = (shreg == {hdmi_cfg_pkg::DEV_ADDR, 1'b0});
					else
						ack = !(byte_cnt == 1 && frame_cnt == i_nack_idx);
					o_sda_low = ack;
					nacked    = nacked || !ack;
				end
				else if (bit_cnt == 9)
				begin
					// ACK slot over, let go of SDA
					o_sda_low = 1'b0;
					bit_cnt   = 0;
					byte_cnt++;
				end
			end
		end
		scl_q = i_scl;
		sda_q = i_sda;
	end

endmodule

`default_nettype wire

// File: dv/tb_hdmi_cam_ctrl_top.sv
/*
 * Testbench for hdmi_cam_ctrl_top with a bridge chip model on open-drain lines.
 * Rows set a NACKed frame, a clock-stretch maximum and a PLL drop mid-run.
 */
`default_nettype none

module tb_hdmi_cam_ctrl_top;

	localparam int         CLK_DIV     = 4;
	localparam int         FIFO_DEPTH  = 4;
	localparam logic [1:0] CBSEL_IMAGE = 2'b01;
	localparam int         NUM_ROWS    = 6;
	localparam int         NO_NACK     = -1;
	localparam int         PW          = hdmi_cfg_pkg::REG_W + hdmi_cfg_pkg::DATA_W;

	typedef struct packed {
		int   nack_idx;
		int   stretch_max;
		logic pll_drop;
	} row_t;

	//////////////////////////////////////////////////
	// Stimulus table
	//////////////////////////////////////////////////
	localparam row_t ROWS [NUM_ROWS] = '{
		'{NO_NACK, 0, 1'b0},
		'{5, 0, 1'b0},
		'{NO_NACK, 24, 1'b0},
		'{0, 12, 1'b0},
		'{NO_NACK, 6, 1'b1},
		'{7, 20, 1'b0}
	};

	logic                     sysclk;
	logic                     arstn;
	logic                     pll_locked;
	logic                     scl_line;
	logic                     sda_line;
	logic                     scl_oe;
	logic                     sda_oe;
	logic                     hdmi_xclr;
	logic                     hdmi_rstn;
	logic                     o_cfg_config;
	logic                     o_cfg_error;
	logic                     o_cfg_ena;
	logic [1:0]               o_cfg_cbsel;
	hdmi_cfg_pkg::i2c_state_e i2c_state;

	logic                     restart;
	int                       nack_idx;
	int                       stretch_max;
	int                       stretch_len;
	int                       stretch_tab [256];
	logic [7:0]               tab_idx;
	logic                     slave_scl_low;
	logic                     slave_sda_low;
	logic                     pair_valid;
	logic [6:0]               pair_addr;
	logic [PW-1:0]            pair_word;

	logic [6:0]               got_addr [$];
	logic [PW-1:0]            got_pair [$];
	int                       err_cnt;
	int                       rows_failed;
	int                       stretch_hits;
	logic                     pll_prev;
	logic                     scl_oe_prev;
	int                       scl_high_run;

	// Wired pull-ups
	assign scl_line = !(scl_oe || slave_scl_low);
	assign sda_line = !(sda_oe || slave_sda_low);

	hdmi_cam_ctrl_top #(
		.CLK_DIV     (CLK_DIV),
		.FIFO_DEPTH  (FIFO_DEPTH),
		.CBSEL_IMAGE (CBSEL_IMAGE)
	) uut (
		.i_sysclk      (sysclk),
		.i_arstn       (arstn),
		.i_pll_locked  (pll_locked),
		.i_hdmi_scl    (scl_line),
		.i_hdmi_sda    (sda_line),
		.o_hdmi_scl_oe (scl_oe),
		.o_hdmi_sda_oe (sda_oe),
		.o_hdmi_xclr   (hdmi_xclr),
		.o_hdmi_rstn   (hdmi_rstn),
		.o_cfg_config  (o_cfg_config),
		.o_cfg_error   (o_cfg_error),
		.o_cfg_ena     (o_cfg_ena),
		.o_cfg_cbsel   (o_cfg_cbsel),
		.o_i2c_state   (i2c_state)
	);

	i2c_slave_model bridge_chip (
		.i_sysclk      (sysclk),
		.i_restart     (restart),
		.i_scl         (scl_line),
		.i_sda         (sda_line),
		.i_nack_idx    (nack_idx),
		.i_stretch_len (stretch_len),
		.o_scl_low     (slave_scl_low),
		.o_sda_low     (slave_sda_low),
		.o_pair_valid  (pair_valid),
		.o_addr        (pair_addr),
		.o_pair        (pair_word)
	);

	initial
	begin
		sysclk = 1'b0;
		forever #10 sysclk = !sysclk;
	end

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////
	task automatic check_bits(input string what, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp)
		begin
			$display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_pair(input string what, input logic [6:0] got_a,
		input logic [PW-1:0] got, input logic [PW-1:0] exp);
		if (got_a !== hdmi_cfg_pkg::DEV_ADDR || got !== exp)
		begin
			$display("Error at %0t: %s got addr %h pair %h, expected addr %h pair %h",
				$time, what, got_a, got, hdmi_cfg_pkg::DEV_ADDR, exp);
			err_cnt++;
		end
	endtask

	task automatic check_state(input string what, input hdmi_cfg_pkg::i2c_state_e got,
		input hdmi_cfg_pkg::i2c_state_e exp);
		if (got !== exp)
		begin
			$display("Error at %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
			err_cnt++;
		end
	endtask

	// Upper bound on run length, in clock cycles
	function automatic int run_limit();
		int max_s;
		max_s = 0;
		for (int i = 0; i < NUM_ROWS; i++)
			if (ROWS[i].stretch_max > max_s)
				max_s = ROWS[i].stretch_max;
		return NUM_ROWS * hdmi_cfg_pkg::CFG_LEN * 30 * (4 * CLK_DIV + max_s) * 2;
	endfunction

	//////////////////////////////////////////////////
	// Stimulus helpers, all leave time at edge + 2
	//////////////////////////////////////////////////
	task automatic cycles(input int n);
		repeat (n) @(posedge sysclk);
		#2;
	endtask

	task automatic restart_bus_model();
		restart <= 1'b1;
		cycles(2);
		restart <= 1'b0;
		got_addr.delete();
		got_pair.delete();
	endtask

	task automatic check_pll_off();
		check_bits("o_hdmi_scl_oe with PLL low", scl_oe, 1'b0);
		check_bits("o_hdmi_sda_oe with PLL low", sda_oe, 1'b0);
		check_bits("o_hdmi_rstn with PLL low", hdmi_rstn, 1'b0);
		check_bits("o_hdmi_xclr with PLL low", hdmi_xclr, 1'b0);
		check_bits("o_cfg_config with PLL low", o_cfg_config, 1'b0);
		check_bits("o_cfg_error with PLL low", o_cfg_error, 1'b0);
	endtask

	task automatic run_row(input int r);
		row_t row;
		int   errs_before;
		int   exp_cnt;
		logic exp_ok;
		row          = ROWS[r];
		errs_before  = err_cnt;
		pll_locked   = 1'b0;
		nack_idx    <= row.nack_idx;
		stretch_max  = row.stretch_max;
		stretch_hits = 0;
		restart_bus_model();
		cycles(1);
		check_pll_off();
		pll_locked = 1'b1;
		if (row.pll_drop)
		begin
			// Lose lock part way into the table
			while (got_pair.size() < 3)
				cycles(1);
			cycles(20);
			pll_locked = 1'b0;
			cycles(3);
			check_pll_off();
			restart_bus_model();
			pll_locked = 1'b1;
		end
		while (!o_cfg_config && !o_cfg_error)
			cycles(1);
		cycles(10);

		exp_ok  = (row.nack_idx == NO_NACK);
		exp_cnt = exp_ok ? hdmi_cfg_pkg::CFG_LEN : row.nack_idx;
		if (got_pair.size() != exp_cnt)
		begin
			$display("Error at %0t: row %0d captured %0d writes where %0d were expected",
				$time, r, got_pair.size(), exp_cnt);
			err_cnt++;
		end
		for (int i = 0; i < exp_cnt && i < got_pair.size(); i++)
			check_pair($sformatf("write %0d", i), got_addr[i], got_pair[i],
				hdmi_cfg_pkg::CFG_TABLE[i]);
		check_bits("o_cfg_config", o_cfg_config, exp_ok);
		check_bits("o_cfg_error", o_cfg_error, !exp_ok);
		check_bits("o_hdmi_scl_oe at end", scl_oe, 1'b0);
		check_bits("o_hdmi_sda_oe at end", sda_oe, 1'b0);
		check_bits("o_hdmi_rstn with PLL locked", hdmi_rstn, 1'b1);
		check_bits("o_hdmi_xclr with PLL locked", hdmi_xclr, 1'b1);
		check_state("o_i2c_state at end", i2c_state, hdmi_cfg_pkg::ST_IDLE);

		if (err_cnt != errs_before)
			rows_failed++;
		$display("Row %0d: nack %0d, stretch %0d, drop %0b, %0d writes, %0d stretch cycles: %s",
			r, row.nack_idx, row.stretch_max, row.pll_drop, got_pair.size(), stretch_hits,
			(err_cnt == errs_before) ? "ok" : "FAIL");
	endtask

	// New stretch length every cycle from the seeded table
	always @(posedge sysclk)
	begin
		tab_idx     <= tab_idx + 1'b1;
		stretch_len <= stretch_tab[tab_idx] % (stretch_max + 1);
	end

	// Written pairs from the chip model
	always @(negedge sysclk)
	begin
		if (pair_valid)
		begin
			got_addr.push_back(pair_addr);
			got_pair.push_back(pair_word);
		end
	end

	//////////////////////////////////////////////////
	// Checks that hold on every cycle
	//////////////////////////////////////////////////
	always @(negedge sysclk)
	begin
		check_bits("o_cfg_ena", o_cfg_ena, 1'b1);
		check_bits("o_cfg_cbsel", o_cfg_cbsel, CBSEL_IMAGE);
		// PLL low across a full clock edge
		if (!pll_locked && !pll_prev)
		begin
			check_bits("o_hdmi_scl_oe, PLL off", scl_oe, 1'b0);
			check_bits("o_hdmi_sda_oe, PLL off", sda_oe, 1'b0);
			check_bits("o_cfg_config, PLL off", o_cfg_config, 1'b0);
		end
		// SCL high half a bit once the chip lets go, however long it stretched
		if (scl_oe && !scl_oe_prev && scl_high_run < 2 * CLK_DIV)
		begin
			$display("Error at %0t: SCL high for %0d cycles, expected at least %0d",
				$time, scl_high_run, 2 * CLK_DIV);
			err_cnt++;
		end
		if (scl_line)
			scl_high_run++;
		else
			scl_high_run = 0;
		// Master released SCL but the chip still holds it
		if (slave_scl_low && !scl_oe)
			stretch_hits++;
		pll_prev    = pll_locked;
		scl_oe_prev = scl_oe;
	end

	initial
	begin
		int limit;
		int cyc;
		limit = run_limit();
		cyc   = 0;
		while (cyc < limit)
		begin
			@(posedge sysclk);
			cyc++;
		end
		$display("Timeout: run did not finish within %0d clock cycles", limit);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial
	begin
		int unsigned draw;
		arstn        = 1'b0;
		pll_locked   = 1'b0;
		restart      = 1'b1;
		nack_idx     = NO_NACK;
		stretch_max  = 0;
		stretch_len  = 0;
		tab_idx      = '0;
		err_cnt      = 0;
		rows_failed  = 0;
		stretch_hits = 0;
		pll_prev     = 1'b1;
		scl_oe_prev  = 1'b0;
		scl_high_run = 0;
		draw = $urandom(32'h68523292);
		for (int i = 0; i < 256; i++)
			stretch_tab[i] = int'($urandom_range(0, 1023));

		repeat (5) @(posedge sysclk);
		#2;
		arstn = 1'b1;
		for (int r = 0; r < NUM_ROWS; r++)
			run_row(r);

		$display("Rows: %0d run, %0d failed, %0d errors", NUM_ROWS, rows_failed, err_cnt);
		if (err_cnt == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: hdmi_cam_ctrl_top.f
hdl/hdmi_cfg_pkg.sv
hdl/cfg_rom_sequencer.sv
hdl/i2c_cmd_fifo.sv
hdl/i2c_write_master.sv
hdl/hdmi_bridge_config.sv
hdl/hdmi_cam_ctrl_top.sv
dv/i2c_slave_model.sv
dv/tb_hdmi_cam_ctrl_top.sv

// File: Makefile
# Verilator build and run of the HDMI bridge configuration testbench

SIM  := obj_dir/Vtb_hdmi_cam_ctrl_top
SRCS := $(shell cat hdmi_cam_ctrl_top.f)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): hdmi_cam_ctrl_top.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_hdmi_cam_ctrl_top -f hdmi_cam_ctrl_top.f -Mdir obj_dir

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
